//--- xif_pkg.sv
// Shared widths and encodings for the offload subsystem.
// NR_LANES must stay a power of two so lane indices wrap naturally.
`default_nettype none

package xif_pkg;

  // Datapath widths
  localparam int unsigned XLEN        = 32;
  localparam int unsigned INSTR_WIDTH = 32;
  localparam int unsigned ID_WIDTH    = 4;

  // Destination register index, instruction bits 11 to 7
  localparam int unsigned REG_ADDR_WIDTH = 5;

  // Execution lanes
  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned LANE_IDX_WIDTH = 2;

  // Major opcode handed to the coprocessor
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // Function codes at or above this value are rejected
  localparam logic [2:0] FUNCT_FIRST_UNSUPPORTED = 3'd3;

  // Field positions inside the instruction word
  localparam int unsigned FUNCT_LSB = 12;
  localparam int unsigned FUNCT_MSB = 14;
  localparam int unsigned RD_LSB    = 7;
  localparam int unsigned RD_MSB    = 11;
  localparam int unsigned OPC_MSB   = 6;

  // Operation encoding follows the function code directly
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_XOR = 2'd1,
    OP_MUL = 2'd2
  } xif_op_e;

endpackage

`default_nettype wire

//--- xif_dispatcher.sv
// Accept/ready are purely combinational; the issuing agent must hold its fields until ready.
`default_nettype none

module xif_dispatcher (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_n_i,
  input  wire logic                                  issue_valid_i,
  input  wire logic [xif_pkg::INSTR_WIDTH-1:0]       issue_instr_i,
  input  wire logic [xif_pkg::ID_WIDTH-1:0]          issue_id_i,
  input  wire logic [xif_pkg::XLEN-1:0]              issue_rs1_i,
  input  wire logic [xif_pkg::XLEN-1:0]              issue_rs2_i,
  input  wire logic [xif_pkg::NR_LANES-1:0]          lane_busy_i,
  output logic                                       issue_ready_o,
  output logic                                       issue_accept_o,
  output logic [xif_pkg::NR_LANES-1:0]               lane_start_o,
  output xif_pkg::xif_op_e                           lane_op_o,
  output logic [xif_pkg::ID_WIDTH-1:0]               lane_id_o,
  output logic [xif_pkg::REG_ADDR_WIDTH-1:0]         lane_rd_o,
  output logic [xif_pkg::XLEN-1:0]                   lane_rs1_o,
  output logic [xif_pkg::XLEN-1:0]                   lane_rs2_o
);

  logic [xif_pkg::OPC_MSB:0]              opcode;
  logic [2:0]                             funct;
  logic                                   supported;
  logic                                   any_idle;
  logic [xif_pkg::LANE_IDX_WIDTH-1:0]     idle_idx;

  assign opcode    = issue_instr_i[xif_pkg::OPC_MSB:0];
  assign funct     = issue_instr_i[xif_pkg::FUNCT_MSB:xif_pkg::FUNCT_LSB];
  assign supported = (opcode == xif_pkg::OPCODE_CUSTOM0) &&
                     (funct < xif_pkg::FUNCT_FIRST_UNSUPPORTED);

  // Lowest-numbered idle lane wins, so search from the top down
  always_comb begin
    any_idle = 1'b0;
    idle_idx = '0;
    for (int i = xif_pkg::NR_LANES - 1; i >= 0; i--) begin
      if (!lane_busy_i[i]) begin
        any_idle = 1'b1;
        idle_idx = i[xif_pkg::LANE_IDX_WIDTH-1:0];
      end
    end
  end

  // Unsupported instructions are consumed at once and never reach a lane
  assign issue_ready_o  = !supported || any_idle;
  assign issue_accept_o = supported && any_idle;

  always_comb begin
    lane_start_o = '0;
    if (issue_valid_i && supported && any_idle) begin
      lane_start_o[idle_idx] = 1'b1;
    end
  end

  // Shared payload, captured only by the lane whose start bit is set
  assign lane_op_o  = xif_pkg::xif_op_e'(funct[1:0]);
  assign lane_id_o  = issue_id_i;
  assign lane_rd_o  = issue_instr_i[xif_pkg::RD_MSB:xif_pkg::RD_LSB];
  assign lane_rs1_o = issue_rs1_i;
  assign lane_rs2_o = issue_rs2_i;

  // The busy bits come back from the lanes a cycle behind their start
  a_start_idle_lane : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lane_start_o != '0) |=> ((lane_busy_i & $past(lane_start_o)) == $past(lane_start_o)));

  a_start_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(lane_start_o));

endmodule

`default_nettype wire

//--- xif_lane.sv
// MUL takes XLEN cycles from start to result; ADD and XOR take one.
// A finished result stays on the outputs until the collector grants it.
`default_nettype none

module xif_lane (
  input  wire logic                               clk_i,
  input  wire logic                               rst_n_i,
  input  wire logic                               start_i,
  input  wire xif_pkg::xif_op_e                   op_i,
  input  wire logic [xif_pkg::ID_WIDTH-1:0]       id_i,
  input  wire logic [xif_pkg::REG_ADDR_WIDTH-1:0] rd_i,
  input  wire logic [xif_pkg::XLEN-1:0]           rs1_i,
  input  wire logic [xif_pkg::XLEN-1:0]           rs2_i,
  input  wire logic                               grant_i,
  output logic                                    busy_o,
  output logic                                    res_valid_o,
  output logic [xif_pkg::ID_WIDTH-1:0]            res_id_o,
  output logic [xif_pkg::REG_ADDR_WIDTH-1:0]      res_rd_o,
  output logic [xif_pkg::XLEN-1:0]                res_data_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_DONE
  } lane_state_e;

  lane_state_e                             state_q;
  logic [$clog2(xif_pkg::XLEN)-1:0]        step_q;
  xif_pkg::xif_op_e                        op_q;
  logic [xif_pkg::ID_WIDTH-1:0]            id_q;
  logic [xif_pkg::REG_ADDR_WIDTH-1:0]      rd_q;
  logic [xif_pkg::XLEN-1:0]                opa_q;
  logic [xif_pkg::XLEN-1:0]                opb_q;
  logic [xif_pkg::XLEN-1:0]                acc_q;

  // Step counter starts at 1 because the first multiply step happens on start
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      step_q  <= '0;
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= (op_i == xif_pkg::OP_MUL) ? ST_MUL : ST_DONE;
            step_q  <= 1;
          end
        end
        ST_MUL: begin
          step_q <= step_q + 1'b1;
          if (step_q == xif_pkg::XLEN - 1) begin
            state_q <= ST_DONE;
          end
        end
        default: begin
          if (grant_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Shift-and-add: multiplicand moves left, multiplier moves right
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q <= op_i;
      id_q <= id_i;
      rd_q <= rd_i;
      if (op_i == xif_pkg::OP_MUL) begin
        acc_q <= rs2_i[0] ? rs1_i : '0;
        opa_q <= rs1_i << 1;
        opb_q <= rs2_i >> 1;
      end else begin
        opa_q <= rs1_i;
        opb_q <= rs2_i;
      end
    end else if (state_q == ST_MUL) begin
      acc_q <= acc_q + (opb_q[0] ? opa_q : '0);
      opa_q <= opa_q << 1;
      opb_q <= opb_q >> 1;
    end
  end

  // Operands are held in opa/opb, so ADD and XOR results stay stable
  always_comb begin
    unique case (op_q)
      xif_pkg::OP_ADD: res_data_o = opa_q + opb_q;
      xif_pkg::OP_XOR: res_data_o = opa_q ^ opb_q;
      default:         res_data_o = acc_q;
    endcase
  end

  assign busy_o      = (state_q != ST_IDLE);
  assign res_valid_o = (state_q == ST_DONE);
  assign res_id_o    = id_q;
  assign res_rd_o    = rd_q;

  a_grant_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    grant_i |-> res_valid_o);

  a_no_start_when_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

//--- xif_collector.sv
// Round-robin over lanes; a lane offered while stalled stays selected until it is taken.
`default_nettype none

module xif_collector (
  input  wire logic                                                     clk_i,
  input  wire logic                                                     rst_n_i,
  input  wire logic [xif_pkg::NR_LANES-1:0]                             res_valid_i,
  input  wire logic [xif_pkg::NR_LANES-1:0][xif_pkg::ID_WIDTH-1:0]      res_id_i,
  input  wire logic [xif_pkg::NR_LANES-1:0][xif_pkg::REG_ADDR_WIDTH-1:0] res_rd_i,
  input  wire logic [xif_pkg::NR_LANES-1:0][xif_pkg::XLEN-1:0]          res_data_i,
  input  wire logic                                                     result_ready_i,
  output logic [xif_pkg::NR_LANES-1:0]                                  res_grant_o,
  output logic                                                          result_valid_o,
  output logic [xif_pkg::ID_WIDTH-1:0]                                  result_id_o,
  output logic [xif_pkg::REG_ADDR_WIDTH-1:0]                            result_rd_o,
  output logic [xif_pkg::XLEN-1:0]                                      result_data_o
);

  logic [xif_pkg::LANE_IDX_WIDTH-1:0] ptr_q;
  logic                               lock_q;
  logic [xif_pkg::LANE_IDX_WIDTH-1:0] lock_idx_q;
  logic [xif_pkg::LANE_IDX_WIDTH-1:0] idx;
  logic [xif_pkg::LANE_IDX_WIDTH-1:0] sel_idx;
  logic                               found;
  logic                               transfer;

  // First valid lane at or after the pointer, wrapping around
  always_comb begin
    found   = 1'b0;
    sel_idx = ptr_q;
    idx     = ptr_q;
    for (int i = 0; i < xif_pkg::NR_LANES; i++) begin
      idx = ptr_q + i[xif_pkg::LANE_IDX_WIDTH-1:0];
      if (!found && res_valid_i[idx]) begin
        found   = 1'b1;
        sel_idx = idx;
      end
    end
    // A stalled offer keeps its lane even if an earlier one turns valid
    if (lock_q) begin
      found   = res_valid_i[lock_idx_q];
      sel_idx = lock_idx_q;
    end
  end

  assign result_valid_o = found;
  assign result_id_o    = res_id_i[sel_idx];
  assign result_rd_o    = res_rd_i[sel_idx];
  assign result_data_o  = res_data_i[sel_idx];
  assign transfer       = found && result_ready_i;

  always_comb begin
    res_grant_o = '0;
    if (transfer) begin
      res_grant_o[sel_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (transfer) begin
      ptr_q  <= sel_idx + 1'b1;
      lock_q <= 1'b0;
    end else if (found) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

  a_result_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_data_o)
      && $stable(result_id_o) && $stable(result_rd_o));

endmodule

`default_nettype wire

//--- xif_subsystem.sv
// Offload top: dispatcher, NR_LANES execution lanes and the result collector.
`default_nettype none

module xif_subsystem (
  input  wire logic                               clk_i,
  input  wire logic                               rst_n_i,
  input  wire logic                               issue_valid_i,
  input  wire logic [xif_pkg::INSTR_WIDTH-1:0]    issue_instr_i,
  input  wire logic [xif_pkg::ID_WIDTH-1:0]       issue_id_i,
  input  wire logic [xif_pkg::XLEN-1:0]           issue_rs1_i,
  input  wire logic [xif_pkg::XLEN-1:0]           issue_rs2_i,
  input  wire logic                               result_ready_i,
  output logic                                    issue_ready_o,
  output logic                                    issue_accept_o,
  output logic                                    result_valid_o,
  output logic [xif_pkg::ID_WIDTH-1:0]            result_id_o,
  output logic [xif_pkg::REG_ADDR_WIDTH-1:0]      result_rd_o,
  output logic [xif_pkg::XLEN-1:0]                result_data_o
);

  // Dispatcher to lanes
  logic [xif_pkg::NR_LANES-1:0]                               lane_start;
  logic [xif_pkg::NR_LANES-1:0]                               lane_busy;
  xif_pkg::xif_op_e                                           lane_op;
  logic [xif_pkg::ID_WIDTH-1:0]                               lane_id;
  logic [xif_pkg::REG_ADDR_WIDTH-1:0]                         lane_rd;
  logic [xif_pkg::XLEN-1:0]                                   lane_rs1;
  logic [xif_pkg::XLEN-1:0]                                   lane_rs2;

  // Lanes to collector
  logic [xif_pkg::NR_LANES-1:0]                               res_valid;
  logic [xif_pkg::NR_LANES-1:0]                               res_grant;
  logic [xif_pkg::NR_LANES-1:0][xif_pkg::ID_WIDTH-1:0]        res_id;
  logic [xif_pkg::NR_LANES-1:0][xif_pkg::REG_ADDR_WIDTH-1:0]  res_rd;
  logic [xif_pkg::NR_LANES-1:0][xif_pkg::XLEN-1:0]            res_data;

  xif_dispatcher i_dispatcher (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .issue_valid_i  ( issue_valid_i  ),
    .issue_instr_i  ( issue_instr_i  ),
    .issue_id_i     ( issue_id_i     ),
    .issue_rs1_i    ( issue_rs1_i    ),
    .issue_rs2_i    ( issue_rs2_i    ),
    .lane_busy_i    ( lane_busy      ),
    .issue_ready_o  ( issue_ready_o  ),
    .issue_accept_o ( issue_accept_o ),
    .lane_start_o   ( lane_start     ),
    .lane_op_o      ( lane_op        ),
    .lane_id_o      ( lane_id        ),
    .lane_rd_o      ( lane_rd        ),
    .lane_rs1_o     ( lane_rs1       ),
    .lane_rs2_o     ( lane_rs2       )
  );

  for (genvar g = 0; g < xif_pkg::NR_LANES; g++) begin : gen_lane
    xif_lane i_lane (
      .clk_i       ( clk_i         ),
      .rst_n_i     ( rst_n_i       ),
      .start_i     ( lane_start[g] ),
      .op_i        ( lane_op       ),
      .id_i        ( lane_id       ),
      .rd_i        ( lane_rd       ),
      .rs1_i       ( lane_rs1      ),
      .rs2_i       ( lane_rs2      ),
      .grant_i     ( res_grant[g]  ),
      .busy_o      ( lane_busy[g]  ),
      .res_valid_o ( res_valid[g]  ),
      .res_id_o    ( res_id[g]     ),
      .res_rd_o    ( res_rd[g]     ),
      .res_data_o  ( res_data[g]   )
    );
  end

  xif_collector i_collector (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .res_valid_i    ( res_valid      ),
    .res_id_i       ( res_id         ),
    .res_rd_i       ( res_rd         ),
    .res_data_i     ( res_data       ),
    .result_ready_i ( result_ready_i ),
    .res_grant_o    ( res_grant      ),
    .result_valid_o ( result_valid_o ),
    .result_id_o    ( result_id_o    ),
    .result_rd_o    ( result_rd_o    ),
    .result_data_o  ( result_data_o  )
  );

endmodule

`default_nettype wire

//--- xif_scoreboard.sv
// Watches the issue and result ports, predicts every accepted result and compares.
// Samples on the rising edge; the testbench changes inputs only on the falling edge.
`default_nettype none

module xif_scoreboard (
  input  wire logic                               clk_i,
  input  wire logic                               rst_n_i,
  input  wire logic                               issue_valid_i,
  input  wire logic [xif_pkg::INSTR_WIDTH-1:0]    issue_instr_i,
  input  wire logic [xif_pkg::ID_WIDTH-1:0]       issue_id_i,
  input  wire logic [xif_pkg::XLEN-1:0]           issue_rs1_i,
  input  wire logic [xif_pkg::XLEN-1:0]           issue_rs2_i,
  input  wire logic                               issue_ready_i,
  input  wire logic                               issue_accept_i,
  input  wire logic                               result_valid_i,
  input  wire logic                               result_ready_i,
  input  wire logic [xif_pkg::ID_WIDTH-1:0]       result_id_i,
  input  wire logic [xif_pkg::REG_ADDR_WIDTH-1:0] result_rd_i,
  input  wire logic [xif_pkg::XLEN-1:0]           result_data_i,
  output int                                      mismatch_cnt_o,
  output int                                      fault_cnt_o,
  output int                                      pending_o,
  output logic [2**xif_pkg::ID_WIDTH-1:0]         live_ids_o
);

  localparam int unsigned N_IDS  = 2 ** xif_pkg::ID_WIDTH;
  localparam int unsigned RES_W  = xif_pkg::ID_WIDTH + xif_pkg::REG_ADDR_WIDTH + xif_pkg::XLEN;

  logic [xif_pkg::XLEN-1:0]           exp_data  [N_IDS];
  logic [xif_pkg::REG_ADDR_WIDTH-1:0] exp_rd    [N_IDS];
  logic [2:0]                         exp_funct [N_IDS];
  logic [RES_W-1:0]                   prev_q;
  logic                               stall_q;
  logic                               first_q;
  logic [2:0]                         funct;
  logic                               supported;
  logic                               room;

  // Sum, exclusive-or or low word of the full product
  function automatic logic [31:0] ref_result(input logic [2:0] f, input logic [31:0] x,
                                             input logic [31:0] y);
    logic [63:0] prod;
    prod = {32'd0, x} * {32'd0, y};
    case (f)
      3'd0:    ref_result = x + y;
      3'd1:    ref_result = x ^ y;
      default: ref_result = prod[31:0];
    endcase
  endfunction

  function automatic string op_name(input logic [2:0] f);
    op_name = (f == 3'd0) ? "add" : (f == 3'd1) ? "xor" : "mul";
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
    mismatch_cnt_o++;
  endtask

  initial begin
    mismatch_cnt_o = 0;
    fault_cnt_o    = 0;
    pending_o      = 0;
    live_ids_o     = '0;
    stall_q        = 1'b0;
    first_q        = 1'b1;
    prev_q         = '0;
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // First edge out of reset comes before any issue
      if (first_q && (result_valid_i !== 1'b0 || issue_ready_i !== 1'b1)) begin
        $display("after reset result_valid_o is not low or issue_ready_o is not high");
        fault_cnt_o++;
      end
      first_q   = 1'b0;
      funct     = issue_instr_i[xif_pkg::FUNCT_MSB:xif_pkg::FUNCT_LSB];
      supported = (issue_instr_i[6:0] == xif_pkg::OPCODE_CUSTOM0) && (funct <= 3'd2);
      // Every accepted result still owed keeps one lane busy
      room      = pending_o < xif_pkg::NR_LANES;
      if (issue_valid_i) begin
        if (issue_ready_i !== (!supported || room)) begin
          report_mismatch("issue_ready", 32'(!supported || room), 32'(issue_ready_i));
        end
        if (issue_accept_i !== (supported && room)) begin
          report_mismatch("issue_accept", 32'(supported && room), 32'(issue_accept_i));
        end
      end
      if (stall_q && (!result_valid_i || {result_id_i, result_rd_i, result_data_i} != prev_q)) begin
        $display("result port changed while result_ready_i was low");
        fault_cnt_o++;
      end
      stall_q = result_valid_i && !result_ready_i;
      prev_q  = {result_id_i, result_rd_i, result_data_i};
      if (result_valid_i && result_ready_i) begin
        if (!live_ids_o[result_id_i]) begin
          $display("unexpected result with id %0d, nothing with that id is outstanding",
                   result_id_i);
          fault_cnt_o++;
        end else begin
          if (result_data_i !== exp_data[result_id_i]) begin
            report_mismatch({op_name(exp_funct[result_id_i]), " data"},
                            exp_data[result_id_i], result_data_i);
          end
          if (result_rd_i !== exp_rd[result_id_i]) begin
            report_mismatch({op_name(exp_funct[result_id_i]), " rd"},
                            32'(exp_rd[result_id_i]), 32'(result_rd_i));
          end
          live_ids_o[result_id_i] = 1'b0;
          pending_o--;
        end
      end
      if (issue_valid_i && issue_ready_i && supported) begin
        if (live_ids_o[issue_id_i]) begin
          $display("id %0d accepted again before its result came back", issue_id_i);
          fault_cnt_o++;
        end else begin
          pending_o++;
        end
        live_ids_o[issue_id_i] = 1'b1;
        exp_data[issue_id_i]   = ref_result(funct, issue_rs1_i, issue_rs2_i);
        exp_rd[issue_id_i]     = issue_instr_i[xif_pkg::RD_MSB:xif_pkg::RD_LSB];
        exp_funct[issue_id_i]  = funct;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_xif_subsystem.sv
// Random offload traffic with result stalls; xif_scoreboard does all the comparing.
// Ids advance per issued instruction and wait while the same id is still in flight.
`default_nettype none

module tb_xif_subsystem;

  localparam int unsigned N_ARITH    = 40;
  localparam int unsigned N_MUL      = 40;
  localparam int unsigned N_CORNER   = 9;
  localparam int unsigned N_REJECT   = 8;
  localparam int unsigned N_STALL    = 5;
  localparam int unsigned N_INSTR    = N_ARITH + N_MUL + N_CORNER + N_REJECT + N_STALL;
  localparam int unsigned MAX_CYCLES = N_INSTR * (xif_pkg::XLEN + 40) + 200;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic                                   issue_valid_i;
  logic [xif_pkg::INSTR_WIDTH-1:0]        issue_instr_i;
  logic [xif_pkg::ID_WIDTH-1:0]           issue_id_i;
  logic [xif_pkg::XLEN-1:0]               issue_rs1_i;
  logic [xif_pkg::XLEN-1:0]               issue_rs2_i;
  logic                                   result_ready_i;
  logic                                   issue_ready_o;
  logic                                   issue_accept_o;
  logic                                   result_valid_o;
  logic [xif_pkg::ID_WIDTH-1:0]           result_id_o;
  logic [xif_pkg::REG_ADDR_WIDTH-1:0]     result_rd_o;
  logic [xif_pkg::XLEN-1:0]               result_data_o;

  logic [2**xif_pkg::ID_WIDTH-1:0]        live_ids;
  int                                     mismatch_cnt;
  int                                     fault_cnt;
  int                                     pending;
  int                                     tb_faults;
  int                                     cycles;
  int                                     stall_left;
  logic [31:0]                            rand_state;
  logic [31:0]                            ready_state;
  logic [31:0]                            a;
  logic [31:0]                            b;
  logic [31:0]                            r;
  logic                                   ready_rand;
  logic                                   hold_results;

  xif_subsystem UUT (.*);

  xif_scoreboard i_scoreboard (
    .clk_i,
    .rst_n_i,
    .issue_valid_i,
    .issue_instr_i,
    .issue_id_i,
    .issue_rs1_i,
    .issue_rs2_i,
    .issue_ready_i  ( issue_ready_o  ),
    .issue_accept_i ( issue_accept_o ),
    .result_valid_i ( result_valid_o ),
    .result_ready_i,
    .result_id_i    ( result_id_o    ),
    .result_rd_i    ( result_rd_o    ),
    .result_data_i  ( result_data_o  ),
    .mismatch_cnt_o ( mismatch_cnt   ),
    .fault_cnt_o    ( fault_cnt      ),
    .pending_o      ( pending        ),
    .live_ids_o     ( live_ids       )
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    xorshift32 = s ^ (s << 5);
  endfunction

  function automatic logic [31:0] make_instr(input logic [2:0] funct, input logic [4:0] rd);
    make_instr = {17'b0, funct, rd, xif_pkg::OPCODE_CUSTOM0};
  endfunction

  function automatic logic [31:0] corner_val(input int k);
    corner_val = (k == 0) ? 32'd0 : (k == 1) ? 32'd1 : 32'hffff_ffff;
  endfunction

  task automatic draw(output logic [31:0] v);
    rand_state = xorshift32(rand_state);
    v = rand_state;
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic issue(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] rs2);
    while (live_ids[issue_id_i]) begin
      @(negedge clk_i);
    end
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i   = rs1;
    issue_rs2_i   = rs2;
    @(posedge clk_i);
    while (!issue_ready_o) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    issue_id_i    = issue_id_i + 1'b1;
  endtask

  task automatic report_and_finish();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt + tb_faults);
    if (mismatch_cnt == 0 && fault_cnt + tb_faults == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // Result consumer drops ready for random stretches of up to 16 cycles
  assign result_ready_i = ready_rand && !hold_results;

  always @(negedge clk_i) begin
    if (stall_left != 0) begin
      stall_left--;
      ready_rand = 1'b0;
    end else begin
      ready_state = xorshift32(ready_state);
      ready_rand  = (ready_state[2:0] != 3'd0);
      if (!ready_rand) begin
        stall_left = ready_state[6:3];
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d accepted results never arrived", cycles, pending);
      tb_faults++;
      report_and_finish();
    end
  end

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = make_instr(3'd0, 5'd0);
    issue_id_i    = '0;
    issue_rs1_i   = '0;
    issue_rs2_i   = '0;
    ready_rand    = 1'b0;
    hold_results  = 1'b0;
    stall_left    = 0;
    tb_faults     = 0;
    cycles        = 0;
    rand_state    = 32'd63469;
    ready_state   = 32'd63469 ^ 32'h9e37_79b9;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // One idle cycle lets the scoreboard see the port state out of reset
    @(negedge clk_i);
    // Random ADD and XOR
    for (int i = 0; i < N_ARITH; i++) begin
      draw(a);
      draw(b);
      draw(r);
      issue(make_instr({2'b00, r[8]}, r[4:0]), a, b);
    end
    // Random MUL, then every pairing of 0, 1 and all-ones
    for (int i = 0; i < N_MUL; i++) begin
      draw(a);
      draw(b);
      draw(r);
      issue(make_instr(3'd2, r[4:0]), a, b);
    end
    for (int i = 0; i < N_CORNER; i++) begin
      issue(make_instr(3'd2, i[4:0]), corner_val(i / 3), corner_val(i % 3));
    end
    // Foreign opcode first, then function codes 3 to 7
    for (int i = 0; i < N_REJECT; i++) begin
      draw(r);
      if (i < 3) begin
        issue({17'b0, 3'd0, r[4:0], 7'b0110011}, r, ~r);
      end else begin
        issue(make_instr(i[2:0], r[4:0]), r, ~r);
      end
    end
    // Fill all lanes with results held back, then offer one more
    while (pending != 0) begin
      @(negedge clk_i);
    end
    hold_results = 1'b1;
    for (int i = 0; i < N_STALL - 1; i++) begin
      draw(a);
      draw(b);
      issue(make_instr((i == N_STALL - 2) ? 3'd0 : 3'd2, i[4:0]), a, b);
    end
    fork
      issue(make_instr(3'd1, 5'd31), a, b);
      begin
        repeat (xif_pkg::XLEN + 8) @(negedge clk_i);
        hold_results = 1'b0;
      end
    join
    while (pending != 0) begin
      @(negedge clk_i);
    end
    // Give a stray or duplicate result time to show up
    repeat (20) @(negedge clk_i);
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- project.f
xif_pkg.sv
xif_dispatcher.sv
xif_lane.sv
xif_collector.sv
xif_subsystem.sv
xif_scoreboard.sv
tb_xif_subsystem.sv

//--- Bender.yml
package:
  name: xif_subsystem

sources:
  - files:
      - xif_pkg.sv
      - xif_dispatcher.sv
      - xif_lane.sv
      - xif_collector.sv
      - xif_subsystem.sv
  - target: test
    files:
      - xif_scoreboard.sv
      - tb_xif_subsystem.sv
